// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= img_switch_tb
RTL_TOP   ?= img_switch_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== flist.f ====
+incdir+src
src/img_pkg.sv
src/img_pattern_gen.sv
src/img_selector_core.sv
src/img_frame_monitor.sv
src/img_switch_top.sv
verif/img_switch_tb.sv

// ==== src/img_cfg.svh ====
// image switcher configuration
`ifndef IMG_CFG_SVH
`define IMG_CFG_SVH

`define IMG_NUM         4
`define IMG_SEL_WIDTH   2
`define IMG_DATA_WIDTH  24
`define IMG_USER_WIDTH  8

`define IMG_FRAME_W     16
`define IMG_FRAME_H     8

// blanking lengths must be at least one cycle.
// frame periods are 169, 181, 195 and 213 cycles, so no two sources stay aligned.
`define IMG_HBLANK_0    4
`define IMG_HBLANK_1    5
`define IMG_HBLANK_2    6
`define IMG_HBLANK_3    7

`define IMG_VBLANK_0    9
`define IMG_VBLANK_1    13
`define IMG_VBLANK_2    19
`define IMG_VBLANK_3    29

`endif

// ==== src/img_frame_monitor.sv ====
// output frame monitor
`default_nettype none

`include "img_cfg.svh"

module img_frame_monitor
    import img_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       cke,
    input  img_pixel_t pix,
    output logic [15:0] frame_count,
    output logic       frame_error
);

    localparam int UW          = `IMG_USER_WIDTH;
    localparam int FRAME_BEATS = `IMG_FRAME_W * `IMG_FRAME_H;

    logic          in_frame;
    logic [15:0]   beat_cnt;
    logic [UW-1:0] tag;
    logic          beat;
    logic          is_start;
    logic          is_end;
    logic [15:0]   cnt_next;
    logic [UW-1:0] tag_ref;

    assign beat     = cke & pix.valid;
    assign is_start = pix.line_first & pix.pixel_first;
    assign is_end   = pix.line_last & pix.pixel_last;

    // a start beat opens a new count and a new reference tag.
    assign cnt_next = is_start ? 16'd1 : beat_cnt + 16'd1;
    assign tag_ref  = is_start ? pix.user : tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_frame    <= 1'b0;
            beat_cnt    <= '0;
            frame_count <= '0;
            frame_error <= 1'b0;
        end else if (beat && (in_frame || is_start)) begin
            beat_cnt <= cnt_next;
            if (pix.user != tag_ref) begin
                frame_error <= 1'b1;
            end
            if (is_start && in_frame) begin
                frame_error <= 1'b1; // previous frame never ended.
            end
            if (is_end) begin
                in_frame    <= 1'b0;
                frame_count <= frame_count + 16'd1;
                if (cnt_next != 16'(FRAME_BEATS)) begin
                    frame_error <= 1'b1;
                end
            end else begin
                in_frame <= 1'b1;
            end
        end
    end

    // reference tag of the frame in progress.
    always_ff @(posedge clk) begin
        if (beat && is_start) begin
            tag <= pix.user;
        end
    end

endmodule

`default_nettype wire

// ==== src/img_pattern_gen.sv ====
// raster pattern generator
`default_nettype none

`include "img_cfg.svh"

module img_pattern_gen
    import img_pkg::*;
#(
    parameter int SRC_INDEX = 0,
    parameter int H_BLANK   = 4,
    parameter int V_BLANK   = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       cke,
    input  pattern_t   mode,
    output img_pixel_t pix
);

    localparam int X_W   = $clog2(`IMG_FRAME_W);
    localparam int Y_W   = $clog2(`IMG_FRAME_H);
    localparam int DW    = `IMG_DATA_WIDTH;
    localparam int UW    = `IMG_USER_WIDTH;
    localparam int BYTES = DW / 8;

    gen_state_t     state;
    logic [X_W-1:0] x;
    logic [Y_W-1:0] y;
    logic [15:0]    blank_cnt;
    logic           x_last;
    logic           y_last;

    assign x_last = (x == X_W'(`IMG_FRAME_W - 1));
    assign y_last = (y == Y_W'(`IMG_FRAME_H - 1));

    function automatic logic [DW-1:0] pattern_data(pattern_t m, logic [7:0] px,
                                                   logic [7:0] py);
        logic [7:0] k;
        k = 8'(SRC_INDEX);
        case (m)
            PAT_GRADIENT: pattern_data = DW'({py, px, k});
            PAT_BARS:     pattern_data = {BYTES{px >> 2}};
            PAT_CHECKER:  pattern_data = {DW{px[0] ^ py[0]}};
            default:      pattern_data = {BYTES{k}};
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= GEN_ACTIVE;
            x               <= '0;
            y               <= '0;
            blank_cnt       <= '0;
            pix.valid       <= 1'b0;
            pix.de          <= 1'b0;
            pix.line_first  <= 1'b0;
            pix.line_last   <= 1'b0;
            pix.pixel_first <= 1'b0;
            pix.pixel_last  <= 1'b0;
        end else if (cke) begin
            pix.valid       <= 1'b0; // blanking cycles carry no beat.
            pix.de          <= 1'b0;
            pix.line_first  <= 1'b0;
            pix.line_last   <= 1'b0;
            pix.pixel_first <= 1'b0;
            pix.pixel_last  <= 1'b0;
            case (state)
                GEN_ACTIVE: begin
                    pix.valid       <= 1'b1;
                    pix.de          <= 1'b1;
                    pix.pixel_first <= (x == '0);
                    pix.pixel_last  <= x_last;
                    pix.line_first  <= (y == '0);
                    pix.line_last   <= y_last;
                    pix.user        <= UW'(SRC_INDEX);
                    pix.data        <= pattern_data(mode, 8'(x), 8'(y));
                    if (x_last) begin
                        x         <= '0;
                        blank_cnt <= 16'(H_BLANK - 1);
                        state     <= GEN_HBLANK;
                    end else begin
                        x <= x + 1'b1;
                    end
                end
                GEN_HBLANK: begin
                    if (blank_cnt != '0) begin
                        blank_cnt <= blank_cnt - 1'b1;
                    end else if (y_last) begin
                        y         <= '0;
                        blank_cnt <= 16'(V_BLANK - 1); // frame blank follows the last line.
                        state     <= GEN_VBLANK;
                    end else begin
                        y     <= y + 1'b1;
                        state <= GEN_ACTIVE;
                    end
                end
                GEN_VBLANK: begin
                    if (blank_cnt != '0) begin
                        blank_cnt <= blank_cnt - 1'b1;
                    end else begin
                        state <= GEN_ACTIVE;
                    end
                end
                default: state <= GEN_ACTIVE;
            endcase
        end
    end

    a_last_has_valid: assert property (@(posedge clk) disable iff (reset)
        pix.pixel_last |-> pix.valid);

endmodule

`default_nettype wire

// ==== src/img_pkg.sv ====
// image switcher types
`default_nettype none

`include "img_cfg.svh"

package img_pkg;

    // one pixel beat with its frame markers.
    typedef struct packed {
        logic                        line_first;
        logic                        line_last;
        logic                        pixel_first;
        logic                        pixel_last;
        logic                        de;
        logic [`IMG_USER_WIDTH-1:0]  user;
        logic [`IMG_DATA_WIDTH-1:0]  data;
        logic                        valid;
    } img_pixel_t;

    typedef enum logic [1:0] {
        PAT_GRADIENT,
        PAT_BARS,
        PAT_CHECKER,
        PAT_SOLID
    } pattern_t;

    typedef enum logic [1:0] {
        GEN_ACTIVE,
        GEN_HBLANK,
        GEN_VBLANK
    } gen_state_t;

endpackage

`default_nettype wire

// ==== src/img_selector_core.sv ====
// frame-safe stream selector
`default_nettype none

`include "img_cfg.svh"

module img_selector_core
    import img_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cke,
    input  logic [`IMG_SEL_WIDTH-1:0] sel,
    input  img_pixel_t                pix_in [`IMG_NUM],
    output img_pixel_t                pix_out
);

    localparam int SW = `IMG_SEL_WIDTH;
    localparam int UW = `IMG_USER_WIDTH;

    logic [SW-1:0] sel_ff0;
    logic [SW-1:0] sel_ff1;
    logic [SW-1:0] cur_sel;
    logic          change;
    logic          busy;
    img_pixel_t    sel_pix;
    logic          frame_start;
    logic          frame_end;
    logic          pass;

    // sel comes from outside the clock domain.
    always_ff @(posedge clk) begin
        if (cke) begin
            sel_ff0 <= sel;
            sel_ff1 <= sel_ff0;
        end
    end

    assign sel_pix     = pix_in[cur_sel];
    assign frame_start = sel_pix.valid & sel_pix.line_first & sel_pix.pixel_first;
    assign frame_end   = pix_out.valid & pix_out.line_last & pix_out.pixel_last;

    // only whole frames reach the output.
    // a start seen while a change is pending is dropped and the new source is taken.
    assign pass = busy | (frame_start & ~change);

    always_ff @(posedge clk) begin
        if (reset) begin
            change              <= 1'b0;
            busy                <= 1'b0;
            cur_sel             <= sel_ff1;
            pix_out.valid       <= 1'b0;
            pix_out.de          <= 1'b0;
            pix_out.line_first  <= 1'b0;
            pix_out.line_last   <= 1'b0;
            pix_out.pixel_first <= 1'b0;
            pix_out.pixel_last  <= 1'b0;
        end else if (cke) begin
            change <= (cur_sel != sel_ff1);

            if (frame_start && !change) begin
                busy <= 1'b1;
            end else if (frame_end) begin
                busy <= 1'b0;
            end

            if (!frame_start && !busy) begin
                cur_sel <= sel_ff1;
            end

            pix_out.valid       <= pass & sel_pix.valid;
            pix_out.de          <= pass & sel_pix.de;
            pix_out.line_first  <= pass & sel_pix.line_first;
            pix_out.line_last   <= pass & sel_pix.line_last;
            pix_out.pixel_first <= pass & sel_pix.pixel_first;
            pix_out.pixel_last  <= pass & sel_pix.pixel_last;
            pix_out.user        <= sel_pix.user;
            pix_out.data        <= sel_pix.data;
        end
    end

    a_sel_stable_busy: assert property (@(posedge clk) disable iff (reset)
        busy |=> $stable(cur_sel));

    // the generator tags tie every forwarded beat back to the select register.
    a_tag_matches_sel: assert property (@(posedge clk) disable iff (reset)
        pix_out.valid |-> (pix_out.user == UW'(cur_sel)));

endmodule

`default_nettype wire

// ==== src/img_switch_top.sv ====
// video source switcher
`default_nettype none

`include "img_cfg.svh"

module img_switch_top
    import img_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cke,
    input  logic [`IMG_SEL_WIDTH-1:0] sel,
    input  pattern_t                  pattern_mode [`IMG_NUM],
    output img_pixel_t                pix_out,
    output logic [15:0]               frame_count,
    output logic                      frame_error
);

    localparam int H_BLANK [`IMG_NUM] =
        '{`IMG_HBLANK_0, `IMG_HBLANK_1, `IMG_HBLANK_2, `IMG_HBLANK_3};
    localparam int V_BLANK [`IMG_NUM] =
        '{`IMG_VBLANK_0, `IMG_VBLANK_1, `IMG_VBLANK_2, `IMG_VBLANK_3};

    img_pixel_t src_pix [`IMG_NUM];

    for (genvar i = 0; i < `IMG_NUM; i++) begin : g_src
        img_pattern_gen #(
            .SRC_INDEX (i),
            .H_BLANK   (H_BLANK[i]),
            .V_BLANK   (V_BLANK[i])
        ) u_gen (
            .clk   (clk),
            .reset (reset),
            .cke   (cke),
            .mode  (pattern_mode[i]),
            .pix   (src_pix[i])
        );
    end

    img_selector_core u_selector (
        .clk     (clk),
        .reset   (reset),
        .cke     (cke),
        .sel     (sel),
        .pix_in  (src_pix),
        .pix_out (pix_out)
    );

    img_frame_monitor u_monitor (
        .clk         (clk),
        .reset       (reset),
        .cke         (cke),
        .pix         (pix_out),
        .frame_count (frame_count),
        .frame_error (frame_error)
    );

endmodule

`default_nettype wire

// ==== verif/img_switch_tb.sv ====
// image switcher testbench
`default_nettype none

`include "img_cfg.svh"

module img_switch_tb
    import img_pkg::*;
;

    localparam int LOCK_LIMIT  = 3 * 213 + 16; // three periods of the slowest source.
    localparam int FRAME_LIMIT = 2000;

    logic                      clk;
    logic                      reset;
    logic                      cke;
    logic [`IMG_SEL_WIDTH-1:0] sel;
    pattern_t                  pattern_mode [`IMG_NUM];
    img_pixel_t                pix_out;
    logic [15:0]               frame_count;
    logic                      frame_error;

    integer     seed;
    pattern_t   mode_d1 [`IMG_NUM];
    pattern_t   mode_d2 [`IMG_NUM];
    logic [7:0] cur_x;
    logic [7:0] cur_y;
    logic [7:0] bx;
    logic [7:0] by;
    logic [23:0] exp_data;
    logic [3:0]  exp_marks;
    logic [15:0] seen_frames;
    logic        seen_beat;
    logic        locked;
    logic [7:0]  lock_tag;

    img_switch_top UUT (
        .clk          (clk),
        .reset        (reset),
        .cke          (cke),
        .sel          (sel),
        .pattern_mode (pattern_mode),
        .pix_out      (pix_out),
        .frame_count  (frame_count),
        .frame_error  (frame_error)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
        $display("Verification failed");
        $fatal(1, "mismatch in %s", name);
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        $display("Verification failed");
        $fatal(1, "%s", what);
    endtask

    function automatic logic [23:0] rule_data(logic [7:0] k, logic [7:0] x, logic [7:0] y,
                                              pattern_t m);
        logic [7:0] bar;
        bar = x / 8'd4;
        case (m)
            PAT_GRADIENT: rule_data = {y, x, k};
            PAT_BARS:     rule_data = {bar, bar, bar};
            PAT_CHECKER:  rule_data = (x[0] != y[0]) ? 24'hffffff : 24'h000000;
            default:      rule_data = {k, k, k};
        endcase
    endfunction

    // position of the current output beat, rebuilt from its markers.
    always_comb begin
        bx = pix_out.pixel_first ? 8'd0 : cur_x + 8'd1;
        if (pix_out.line_first && pix_out.pixel_first) by = 8'd0;
        else if (pix_out.pixel_first) by = cur_y + 8'd1;
        else by = cur_y;
        exp_data  = rule_data(pix_out.user, bx, by, mode_d2[pix_out.user[1:0]]);
        exp_marks = {by == 8'd0, by == 8'(`IMG_FRAME_H - 1),
                     bx == 8'd0, bx == 8'(`IMG_FRAME_W - 1)};
    end

    always @(posedge clk) begin
        if (reset) begin
            cur_x       <= 8'd0;
            cur_y       <= 8'd0;
            seen_frames <= 16'd0;
            seen_beat   <= 1'b0;
        end else if (cke) begin
            mode_d1 <= pattern_mode; // generator and selector each add one stage.
            mode_d2 <= mode_d1;
            if (pix_out.valid) begin
                seen_beat <= 1'b1;
                cur_x     <= bx;
                cur_y     <= by;
                if (pix_out.line_last && pix_out.pixel_last) seen_frames <= seen_frames + 16'd1;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) cke <= ($random(seed) & 3) != 0;
    end

    a_idle_after_reset: assert property (@(posedge clk) disable iff (reset)
        !seen_beat |-> (frame_count == 16'd0) && !frame_error &&
        (pix_out.valid ? (pix_out.line_first && pix_out.pixel_first) :
        !(pix_out.de | pix_out.line_first | pix_out.line_last |
        pix_out.pixel_first | pix_out.pixel_last)))
        else report_error("output not idle before the first frame");

    a_tag_range: assert property (@(posedge clk) disable iff (reset)
        pix_out.valid |-> pix_out.user < `IMG_NUM)
        else report_mismatch("tag range", `IMG_NUM - 1, $sampled(pix_out.user));

    a_pixel_data: assert property (@(posedge clk) disable iff (reset)
        (cke && pix_out.valid) |-> pix_out.data == exp_data)
        else report_mismatch("pixel data", $sampled(exp_data), $sampled(pix_out.data));

    a_markers: assert property (@(posedge clk) disable iff (reset)
        (cke && pix_out.valid) |-> {pix_out.line_first, pix_out.line_last,
        pix_out.pixel_first, pix_out.pixel_last} == exp_marks)
        else report_mismatch("frame markers", $sampled(exp_marks),
            $sampled({pix_out.line_first, pix_out.line_last,
            pix_out.pixel_first, pix_out.pixel_last}));

    a_de_valid: assert property (@(posedge clk) disable iff (reset)
        pix_out.valid |-> pix_out.de)
        else report_mismatch("data enable", 1, $sampled(pix_out.de));

    a_no_frame_error: assert property (@(posedge clk) disable iff (reset)
        !frame_error)
        else report_mismatch("frame integrity", 0, 1);

    a_frame_count: assert property (@(posedge clk) disable iff (reset)
        frame_count == seen_frames)
        else report_mismatch("frame count", $sampled(seen_frames), $sampled(frame_count));

    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        !cke |=> $stable(pix_out) && $stable(frame_count))
        else report_error("output moved while cke was low");

    a_locked_tag: assert property (@(posedge clk) disable iff (reset)
        (locked && cke && pix_out.valid) |-> pix_out.user == lock_tag)
        else report_mismatch("held select tag", $sampled(lock_tag), $sampled(pix_out.user));

    task automatic wait_lock(input logic [7:0] target);
        int active;
        active = 0;
        forever begin
            @(posedge clk);
            if (cke && pix_out.valid && pix_out.line_first && pix_out.pixel_first &&
                pix_out.user == target) break;
            if (cke) active++;
            if (active > LOCK_LIMIT) report_error("no frame from the new source in time");
        end
    endtask

    task automatic wait_frame_ends(input int n);
        int cycles;
        int ends;
        cycles = 0;
        ends = 0;
        while (ends < n) begin
            @(posedge clk);
            if (cke && pix_out.valid && pix_out.line_last && pix_out.pixel_last) ends++;
            cycles++;
            if (cycles > FRAME_LIMIT) report_error("timed out waiting for frame end");
        end
    endtask

    initial begin
        logic [7:0] target;
        seed     = 9367;
        reset    = 1'b1;
        cke      = 1'b1;
        sel      = '0;
        locked   = 1'b0;
        lock_tag = 8'd0;
        for (int k = 0; k < `IMG_NUM; k++) begin
            pattern_mode[k] = pattern_t'(k);
            mode_d1[k]      = pattern_t'(k);
            mode_d2[k]      = pattern_t'(k);
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        for (int p = 0; p < 8; p++) begin
            target = 8'($random(seed) & 3);
            for (int k = 0; k < `IMG_NUM; k++) begin
                pattern_mode[k] <= pattern_t'((p + k - target) & 3); // target gets opcode p.
            end
            repeat (3) begin
                sel <= `IMG_SEL_WIDTH'($random(seed) & 3);
                repeat (5 + ($random(seed) & 63)) @(posedge clk);
            end
            sel <= target[`IMG_SEL_WIDTH-1:0];
            wait_lock(target);
            locked   <= 1'b1;
            lock_tag <= target;
            wait_frame_ends(2);
            locked <= 1'b0;
        end
        repeat (4) @(posedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire
